// File: list.f
logic/sink_pkg.sv
logic/sink_addr_gen.sv
logic/sink_addr_fifo.sv
logic/stream_sink.sv
logic/scratch_bank.sv
logic/sink_top.sv
sim/tb_clock.sv
sim/tb_sink_top.sv

// File: logic/scratch_bank.sv
// Word-addressed scratchpad with byte enables, debug-first arbitration and registered read.
module scratch_bank #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  sink_pkg::mem_req_t          wr_req_i,
  output logic                        wr_gnt_o,
  input  logic                        dbg_req_i,
  input  logic [sink_pkg::ADDR_W-1:0] dbg_addr_i,
  output logic [sink_pkg::DATA_W-1:0] dbg_rdata_o
);
  import sink_pkg::*;

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [MEM_WORDS-1:0] written_q;
  logic [DATA_W-1:0]    rdata_q;
  logic [IDX_W-1:0]     wr_idx, rd_idx;
  logic [DATA_W-1:0]    old_word;
  logic                 do_write;

  // Debug reads win, the streamer waits a cycle.
  assign wr_gnt_o = wr_req_i.req & ~dbg_req_i;
  assign do_write = wr_gnt_o & ~wr_req_i.wen;

  assign wr_idx = IDX_W'(wr_req_i.add[ADDR_W-1:2] % MEM_WORDS);
  assign rd_idx = IDX_W'(dbg_addr_i % MEM_WORDS);

  // Words never written read back as zero.
  assign old_word = written_q[wr_idx] ? mem_q[wr_idx] : '0;

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int b = 0; b < STRB_W; b++) begin
        mem_q[wr_idx][8*b +: 8] <= wr_req_i.be[b] ? wr_req_i.data[8*b +: 8]
                                                  : old_word[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      written_q <= '0;
    end else if (do_write) begin
      written_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (dbg_req_i) begin
      rdata_q <= written_q[rd_idx] ? mem_q[rd_idx] : '0;
    end
  end

  assign dbg_rdata_o = rdata_q;

endmodule

// File: logic/sink_addr_fifo.sv
// Circular valid/ready FIFO for word addresses with an occupancy count.
module sink_addr_fifo #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic [sink_pkg::ADDR_W-1:0] push_data_i,
  input  logic                        push_valid_i,
  output logic                        push_ready_o,
  output logic [sink_pkg::ADDR_W-1:0] pop_data_o,
  output logic                        pop_valid_o,
  input  logic                        pop_ready_i
);
  import sink_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [ADDR_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push, pop;

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      // Simultaneous push and pop leave the count unchanged.
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// File: logic/sink_addr_gen.sv
// Strided word-address generator with presampled control fields and a done flag.
module sink_addr_gen #(
  parameter int unsigned CNT_W = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      enable_i,
  input  logic                      presample_i,
  input  sink_pkg::addr_ctrl_t      ctrl_i,
  output logic [sink_pkg::ADDR_W-1:0] addr_o,
  output logic                      addr_valid_o,
  input  logic                      addr_ready_i,
  output logic                      done_o
);
  import sink_pkg::*;

  addr_ctrl_t        ctrl_q;
  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  count_q;
  logic              active_q;
  logic              done_q;
  logic              accept;
  logic              last_addr;

  assign addr_valid_o = enable_i & active_q;
  assign addr_o       = addr_q;
  assign done_o       = done_q;

  assign accept    = addr_valid_o & addr_ready_i;
  assign last_addr = (count_q == (ctrl_q.word_length[CNT_W-1:0] - CNT_W'(1)));

  // Job progress and completion.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      count_q  <= '0;
      done_q   <= 1'b0;
    end else if (clear_i) begin
      active_q <= 1'b0;
      count_q  <= '0;
      done_q   <= 1'b0;
    end else if (presample_i) begin
      active_q <= 1'b1;
      count_q  <= '0;
      done_q   <= 1'b0;
    end else if (accept) begin
      count_q <= count_q + CNT_W'(1);
      if (last_addr) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

  // Sampled job fields and the running address.
  always_ff @(posedge clk_i) begin
    if (presample_i) begin
      ctrl_q <= ctrl_i;
      addr_q <= ctrl_i.base_addr;
    end else if (accept) begin
      // Stride is signed, two's complement wrap gives negative steps.
      addr_q <= addr_q + ctrl_q.word_stride;
    end
  end

endmodule

// File: logic/sink_pkg.sv
// Width constants, control and flag structs, stream beat, memory request and FSM state enum.
package sink_pkg;

  // Stream and memory word width.
  localparam int unsigned DATA_W = 32;
  // Width of byte and word address fields.
  localparam int unsigned ADDR_W = 32;
  // One byte enable per byte of the word.
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef enum logic [1:0] {
    SINK_IDLE,
    SINK_WORKING,
    SINK_DONE
  } sink_state_e;

  // Job description, all fields counted in words.
  typedef struct packed {
    logic        [ADDR_W-1:0] base_addr;
    logic        [ADDR_W-1:0] word_length;
    logic signed [ADDR_W-1:0] word_stride;
  } addr_ctrl_t;

  typedef struct packed {
    logic       req_start;
    addr_ctrl_t addr_ctrl;
  } sink_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
    logic addr_done;
  } sink_flags_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } stream_beat_t;

  // Scratchpad request, wen is active low.
  typedef struct packed {
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] add;
    logic [STRB_W-1:0] be;
    logic [DATA_W-1:0] data;
  } mem_req_t;

endpackage

// File: logic/sink_top.sv
// Top level joining the write streamer to the scratchpad bank.
module sink_top #(
  parameter int unsigned CNT_W      = 16,
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned MEM_WORDS  = 256
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  sink_pkg::sink_ctrl_t        ctrl_i,
  output sink_pkg::sink_flags_t       flags_o,
  input  logic                        stream_valid_i,
  input  sink_pkg::stream_beat_t      stream_i,
  output logic                        stream_ready_o,
  input  logic                        dbg_req_i,
  input  logic [sink_pkg::ADDR_W-1:0] dbg_addr_i,
  output logic [sink_pkg::DATA_W-1:0] dbg_rdata_o
);
  import sink_pkg::*;

  mem_req_t mem_req;
  logic     mem_gnt;

  stream_sink #(
    .CNT_W      ( CNT_W      ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_stream_sink (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .ctrl_i         ( ctrl_i         ),
    .flags_o        ( flags_o        ),
    .stream_valid_i ( stream_valid_i ),
    .stream_i       ( stream_i       ),
    .stream_ready_o ( stream_ready_o ),
    .mem_req_o      ( mem_req        ),
    .mem_gnt_i      ( mem_gnt        )
  );

  scratch_bank #(
    .MEM_WORDS ( MEM_WORDS )
  ) i_scratch_bank (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .wr_req_i    ( mem_req     ),
    .wr_gnt_o    ( mem_gnt     ),
    .dbg_req_i   ( dbg_req_i   ),
    .dbg_addr_i  ( dbg_addr_i  ),
    .dbg_rdata_o ( dbg_rdata_o )
  );

endmodule

// File: logic/stream_sink.sv
// Write streamer with job FSM, stream-to-memory binding, address count and done flag.
module stream_sink #(
  parameter int unsigned CNT_W      = 16,
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  sink_pkg::sink_ctrl_t   ctrl_i,
  output sink_pkg::sink_flags_t  flags_o,
  input  logic                   stream_valid_i,
  input  sink_pkg::stream_beat_t stream_i,
  output logic                   stream_ready_o,
  output sink_pkg::mem_req_t     mem_req_o,
  input  logic                   mem_gnt_i
);
  import sink_pkg::*;

  sink_state_e       cs_q, ns_d;
  logic              gen_en, gen_clr, gen_presample, gen_done;
  logic [ADDR_W-1:0] gen_addr;
  logic              gen_valid, gen_ready;
  logic [ADDR_W-1:0] fifo_addr;
  logic              fifo_valid, fifo_ready;
  logic [CNT_W-1:0]  len_q, cnt_q;
  logic              cnt_clr;
  logic              done;
  logic              active;

  // A start request is only taken while idle.
  assign gen_presample = ctrl_i.req_start & (cs_q == SINK_IDLE);

  sink_addr_gen #(
    .CNT_W ( CNT_W )
  ) i_addr_gen (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .clear_i      ( gen_clr          ),
    .enable_i     ( gen_en           ),
    .presample_i  ( gen_presample    ),
    .ctrl_i       ( ctrl_i.addr_ctrl ),
    .addr_o       ( gen_addr         ),
    .addr_valid_o ( gen_valid        ),
    .addr_ready_i ( gen_ready        ),
    .done_o       ( gen_done         )
  );

  sink_addr_fifo #(
    .DEPTH ( FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_data_i  ( gen_addr   ),
    .push_valid_i ( gen_valid  ),
    .push_ready_o ( gen_ready  ),
    .pop_data_o   ( fifo_addr  ),
    .pop_valid_o  ( fifo_valid ),
    .pop_ready_i  ( fifo_ready )
  );

  // Memory port binding, word address to byte address.
  assign active          = (cs_q != SINK_IDLE);
  assign mem_req_o.req   = active & stream_valid_i & fifo_valid;
  assign mem_req_o.wen   = 1'b0;
  assign mem_req_o.add   = active ? {fifo_addr[ADDR_W-3:0], 2'b00} : '0;
  assign mem_req_o.be    = active ? stream_i.strb : '0;
  assign mem_req_o.data  = active ? stream_i.data : '0;

  assign stream_ready_o = ~stream_valid_i | (mem_gnt_i & fifo_valid);
  // Each stream transfer consumes exactly one address.
  assign fifo_ready     = stream_valid_i & stream_ready_o;

  assign flags_o.ready_start = (cs_q == SINK_IDLE) | done;
  assign flags_o.done        = done;
  assign flags_o.addr_done   = gen_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs_q <= SINK_IDLE;
    end else if (clear_i) begin
      cs_q <= SINK_IDLE;
    end else begin
      cs_q <= ns_d;
    end
  end

  always_comb begin
    ns_d    = cs_q;
    done    = 1'b0;
    gen_en  = 1'b0;
    gen_clr = clear_i;
    cnt_clr = 1'b0;
    case (cs_q)
      SINK_IDLE: begin
        if (ctrl_i.req_start) begin
          ns_d   = SINK_WORKING;
          gen_en = 1'b1;
        end
      end
      SINK_WORKING: begin
        gen_en = 1'b1;
        if (gen_done) begin
          ns_d = SINK_DONE;
        end
      end
      SINK_DONE: begin
        gen_en = 1'b1;
        // All addresses handed out, wait for the last write.
        if (cnt_q == len_q) begin
          ns_d    = SINK_IDLE;
          done    = 1'b1;
          gen_en  = 1'b0;
          gen_clr = 1'b1;
          cnt_clr = 1'b1;
        end
      end
      default: ns_d = SINK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || cnt_clr) begin
      cnt_q <= '0;
    end else if (fifo_valid && fifo_ready) begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (gen_presample) begin
      len_q <= ctrl_i.addr_ctrl.word_length[CNT_W-1:0];
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_sink_top -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_sink_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TESTS PASSED'; then
  exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// File: sim/tb_clock.sv
// Testbench clock and reset generator, 10 ns period.
module tb_clock #(
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, away from the sampling edge.
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: sim/tb_sink_top.sv
// Testbench for the write streamer with LFSR stimulus, directed tests, watchdog and summary.
module tb_sink_top;
  timeunit 1ns;
  timeprecision 1ps;
  import sink_pkg::*;

  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned IDX_W       = $clog2(MEM_WORDS);
  localparam int unsigned TOTAL_BEATS = 114;
  localparam int unsigned TOTAL_READS = 208;
  // Up to three gap cycles per beat plus debug contention, then a margin of four.
  localparam int unsigned WATCHDOG_CYCLES = 4 * (TOTAL_BEATS * 6 + TOTAL_READS * 3) + 500;

  logic              clk;
  logic              rst_n;
  logic              clear;
  sink_ctrl_t        ctrl;
  sink_flags_t       flags;
  logic              stream_valid;
  stream_beat_t      stream_beat;
  logic              stream_ready;
  logic              dbg_req;
  logic [ADDR_W-1:0] dbg_addr;
  logic [DATA_W-1:0] dbg_rdata;

  logic [DATA_W-1:0] exp_mem [MEM_WORDS];
  logic [31:0]       lfsr_q;
  int unsigned       errors = 0;
  int unsigned       checks = 0;
  int unsigned       done_pulses = 0;

  tb_clock i_tb_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  sink_top #(
    .CNT_W      ( 16        ),
    .FIFO_DEPTH ( 4         ),
    .MEM_WORDS  ( MEM_WORDS )
  ) i_sink_top (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .clear_i        ( clear        ),
    .ctrl_i         ( ctrl         ),
    .flags_o        ( flags        ),
    .stream_valid_i ( stream_valid ),
    .stream_i       ( stream_beat  ),
    .stream_ready_o ( stream_ready ),
    .dbg_req_i      ( dbg_req      ),
    .dbg_addr_i     ( dbg_addr     ),
    .dbg_rdata_o    ( dbg_rdata    )
  );

  // Every cycle with done high counts, so a long pulse shows up as two.
  always @(negedge clk) begin
    if (rst_n && flags.done) begin
      done_pulses++;
    end
  end

  // Fibonacci LFSR, polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Expected word update, only bytes with their strobe set change.
  function automatic void apply_write(input logic [IDX_W-1:0] word, input stream_beat_t beat);
    logic [DATA_W-1:0] mask;
    mask = {{8{beat.strb[3]}}, {8{beat.strb[2]}}, {8{beat.strb[1]}}, {8{beat.strb[0]}}};
    exp_mem[word] = (exp_mem[word] & ~mask) | (beat.data & mask);
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic dbg_read(input logic [IDX_W-1:0] word, output logic [DATA_W-1:0] data);
    @(posedge clk);
    dbg_req  <= 1'b1;
    dbg_addr <= ADDR_W'(word);
    @(posedge clk);
    dbg_req <= 1'b0;
    @(negedge clk);
    data = dbg_rdata;
  endtask

  task automatic check_range(input int unsigned lo, input int unsigned hi);
    logic [DATA_W-1:0] data;
    for (int unsigned w = lo; w <= hi; w++) begin
      dbg_read(IDX_W'(w), data);
      check_eq(data, exp_mem[IDX_W'(w)], $sformatf("debug read of word %0d", w));
    end
  endtask

  task automatic start_job(input int unsigned base, input int unsigned len,
                           input int unsigned stride);
    @(negedge clk);
    check_eq(32'(flags.ready_start), 32'd1, "ready_start before job");
    @(posedge clk);
    ctrl.req_start             <= 1'b1;
    ctrl.addr_ctrl.base_addr   <= ADDR_W'(base);
    ctrl.addr_ctrl.word_length <= ADDR_W'(len);
    ctrl.addr_ctrl.word_stride <= ADDR_W'(stride);
    @(posedge clk);
    ctrl.req_start <= 1'b0;
  endtask

  // Beat i lands on word base + i * stride.
  task automatic stream_job(input int unsigned base, input int unsigned len,
                            input int unsigned stride, input bit rand_strb,
                            input bit rand_gaps);
    stream_beat_t beat;
    for (int unsigned i = 0; i < len; i++) begin
      beat.data = rand_bits(32);
      beat.strb = rand_strb ? STRB_W'(rand_bits(4)) : '1;
      if (rand_gaps) begin
        repeat (rand_bits(2)) begin
          @(posedge clk);
          stream_valid <= 1'b0;
        end
      end
      @(posedge clk);
      stream_valid <= 1'b1;
      stream_beat  <= beat;
      do begin
        @(negedge clk);
      end while (!stream_ready);
      apply_write(IDX_W'(base + i * stride), beat);
    end
    @(posedge clk);
    stream_valid <= 1'b0;
  endtask

  task automatic finish_job(input int unsigned pulses_before);
    int unsigned n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!flags.done && n < 64);
    checks++;
    assert (flags.done) else begin
      errors++;
      $display("The done flag did not rise within 64 cycles of the last beat, at %0t", $time);
    end
    check_eq(32'(flags.ready_start), 32'd1, "ready_start with done");
    check_eq(32'(flags.addr_done), 32'd1, "addr_done with done");
    repeat (4) @(negedge clk);
    check_eq(done_pulses - pulses_before, 32'd1, "done pulse count");
    check_eq(32'(flags.ready_start), 32'd1, "ready_start after job");
  endtask

  task automatic run_job(input int unsigned base, input int unsigned len,
                         input int unsigned stride, input bit rand_strb, input bit rand_gaps);
    int unsigned pulses_before;
    pulses_before = done_pulses;
    start_job(base, len, stride);
    stream_job(base, len, stride, rand_strb, rand_gaps);
    finish_job(pulses_before);
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    $display("%s: %0d errors", name, errors - errors_before);
  endtask

  task automatic check_reset_state();
    int unsigned errors_before;
    errors_before = errors;
    @(negedge clk);
    check_eq(32'(flags.ready_start), 32'd1, "ready_start after reset");
    check_eq(32'(flags.done), 32'd0, "done after reset");
    check_eq(32'(flags.addr_done), 32'd0, "addr_done after reset");
    check_eq(32'(stream_ready), 32'd1, "stream ready with no beat offered");
    // An offered beat is refused while idle.
    @(posedge clk);
    stream_valid <= 1'b1;
    stream_beat  <= '{data: 32'hdeadbeef, strb: 4'hf};
    @(negedge clk);
    check_eq(32'(stream_ready), 32'd0, "stream ready with a beat while idle");
    @(posedge clk);
    stream_valid <= 1'b0;
    check_range(0, 15);
    report_test("reset_state", errors_before);
  endtask

  task automatic contiguous_job();
    int unsigned errors_before;
    errors_before = errors;
    run_job(16, 16, 1, 1'b0, 1'b0);
    check_range(0, 47);
    report_test("contiguous_job", errors_before);
  endtask

  task automatic strided_partial_job();
    int unsigned errors_before;
    errors_before = errors;
    run_job(64, 36, 1, 1'b0, 1'b0);
    run_job(64, 12, 3, 1'b1, 1'b0);
    check_range(64, 103);
    report_test("strided_partial_job", errors_before);
  endtask

  task automatic backpressure_job();
    int unsigned       errors_before;
    int unsigned       pulses_before;
    logic [DATA_W-1:0] data;
    errors_before = errors;
    pulses_before = done_pulses;
    start_job(128, 20, 2);
    fork
      begin
        stream_job(128, 20, 2, 1'b0, 1'b1);
        finish_job(pulses_before);
      end
      begin
        // Debug reads of earlier data steal bank cycles from the job.
        for (int unsigned k = 0; k < 16; k++) begin
          repeat (k % 3) @(posedge clk);
          dbg_read(IDX_W'(16 + k), data);
          check_eq(data, exp_mem[IDX_W'(16 + k)], $sformatf("word %0d during job", 16 + k));
        end
      end
    join
    check_range(120, 175);
    report_test("backpressure_job", errors_before);
  endtask

  task automatic clear_mid_job();
    int unsigned errors_before;
    int unsigned pulses_before;
    errors_before = errors;
    pulses_before = done_pulses;
    start_job(200, 16, 1);
    // Enough beats for the generator to hand out every address.
    stream_job(200, 14, 1, 1'b0, 1'b0);
    repeat (4) @(negedge clk);
    check_eq(32'(flags.addr_done), 32'd1, "addr_done before clear");
    check_eq(32'(flags.ready_start), 32'd0, "ready_start before clear");
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    repeat (6) @(negedge clk);
    check_eq(32'(flags.ready_start), 32'd1, "ready_start after clear");
    check_eq(32'(flags.addr_done), 32'd0, "addr_done after clear");
    check_eq(done_pulses - pulses_before, 32'd0, "done pulses after clear");
    run_job(200, 16, 1, 1'b0, 1'b0);
    check_range(192, 223);
    report_test("clear_mid_job", errors_before);
  endtask

  initial begin
    lfsr_q       = 32'had55;
    clear        = 1'b0;
    ctrl         = '0;
    stream_valid = 1'b0;
    stream_beat  = '0;
    dbg_req      = 1'b0;
    dbg_addr     = '0;
    exp_mem      = '{default: '0};
    do begin
      @(posedge clk);
    end while (!rst_n);
    check_reset_state();
    contiguous_job();
    strided_partial_job();
    backpressure_job();
    clear_mid_job();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
